/* all.f */
+incdir+common
common/hdr_pkg.sv
rtl/hdr_engine/hdr_engine.sv
rtl/hdr_engine/hdr_ccc_seq.sv
rtl/hdr_engine/hdr_ddr_seq.sv
rtl/hdr_engine/hdr_path_mux.sv
rtl/hdr_top.sv
tb/hdr_checker.sv
tb/hdr_tb.sv

/* tb/hdr_tb.sv */
// HDR subsystem testbench
// seeded random chains of CCC and DDR transfers plus mid-transfer aborts;
// a transfer model feeds the checker, which compares the DUT ports

`default_nettype none

`include "hdr_defines.svh"

module hdr_tb;

  localparam int NUM_TESTS  = 30;
  localparam int WAIT_LIMIT = 200;   // well above the longest chain step in cycles

  logic                   sys_clk;
  logic                   sys_rst_n;
  logic                   hdr_en;
  logic                   cp;
  logic                   toc;
  logic [2:0]             mode;
  logic [`HDR_LEN_W-1:0]  ccc_words;
  logic [`HDR_LEN_W-1:0]  ddr_words;
  logic [`HDR_DATA_W-1:0] regf_rd_data;
  logic                   tx_en;
  logic                   scl_pp_od;
  logic                   regf_rd_en;
  logic [`HDR_ADDR_W-1:0] regf_addr;
  logic [`HDR_DATA_W-1:0] tx_data;
  logic                   hdr_done;
  logic                   ccc_active;
  logic                   ddr_active;
  integer                 error_count;
  integer                 check_count;
  integer                 failed_tests;
  integer                 seed;
  bit                     timed_out;
  int                     t;
  int                     r;

  hdr_top u_hdr_top (
    .i_sys_clk      (sys_clk),
    .i_sys_rst_n    (sys_rst_n),
    .i_hdr_en       (hdr_en),
    .i_cp           (cp),
    .i_toc          (toc),
    .i_mode         (mode),
    .i_ccc_words    (ccc_words),
    .i_ddr_words    (ddr_words),
    .i_regf_rd_data (regf_rd_data),
    .o_tx_en        (tx_en),
    .o_scl_pp_od    (scl_pp_od),
    .o_regf_rd_en   (regf_rd_en),
    .o_regf_addr    (regf_addr),
    .o_tx_data      (tx_data),
    .o_hdr_done     (hdr_done),
    .o_ccc_active   (ccc_active),
    .o_ddr_active   (ddr_active)
  );

  hdr_checker u_hdr_checker (
    .i_sys_clk      (sys_clk),
    .i_sys_rst_n    (sys_rst_n),
    .i_hdr_en       (hdr_en),
    .i_ccc_active   (ccc_active),
    .i_ddr_active   (ddr_active),
    .i_hdr_done     (hdr_done),
    .i_tx_en        (tx_en),
    .i_scl_pp_od    (scl_pp_od),
    .i_regf_rd_en   (regf_rd_en),
    .i_regf_addr    (regf_addr),
    .i_regf_rd_data (regf_rd_data),
    .i_tx_data      (tx_data),
    .o_error_count  (error_count),
    .o_check_count  (check_count),
    .o_failed_tests (failed_tests)
  );

  initial begin
    sys_clk = 1'b0;
    forever #50 sys_clk = ~sys_clk;
  end

  function automatic int rand_range(input int lo, input int hi);
    rand_range = lo + ({$random(seed)} % (hi - lo + 1));
  endfunction

  // one transfer's config where only the last of a chain may exit
  task automatic set_config(input bit is_ccc, input int words, input bit last);
    int m;
    cp        = is_ccc;
    ccc_words = words[`HDR_LEN_W-1:0];
    ddr_words = words[`HDR_LEN_W-1:0];
    toc       = 1'b0;
    m         = `HDR_MODE_DDR;
    if (last) begin
      if (rand_range(0, 1) == 1) begin
        toc = 1'b1;                                   // exit on toc in any mode
        m   = rand_range(0, 7);
      end else begin
        m = (`HDR_MODE_DDR + rand_range(1, 7)) % 8;  // non-DDR mode with toc clear
      end
    end
    mode = m[2:0];
  endtask

  task automatic wait_rise(input bit is_ccc);
    int  n;
    bit  prev;
    bit  cur;
    bit  seen;
    n    = 0;
    seen = 1'b0;
    prev = is_ccc ? ccc_active : ddr_active;
    while (!seen && !timed_out) begin
      @(negedge sys_clk);
      cur  = is_ccc ? ccc_active : ddr_active;
      seen = cur && !prev;
      prev = cur;
      n++;
      if (!seen && n > WAIT_LIMIT) begin
        $display("timeout: %s never rose", is_ccc ? "o_ccc_active" : "o_ddr_active");
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (!hdr_done && !timed_out) begin
      @(negedge sys_clk);
      n++;
      if (!hdr_done && n > WAIT_LIMIT) begin
        $display("timeout: o_hdr_done never pulsed at the end of the chain");
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic run_chain();
    bit is_ccc[4];
    int words[4];
    int n;
    int k;
    n = rand_range(1, 4);
    for (k = 0; k < n; k++) begin
      is_ccc[k] = (rand_range(0, 1) == 1);
      words[k]  = rand_range(1, 6);
      // CCC into DDR runs one dummy CCC word first
      if (k > 0 && is_ccc[k-1] && !is_ccc[k])
        u_hdr_checker.push_expect(1'b1, 1'b1, 1, 1'b0, 1'b0);
      u_hdr_checker.push_expect(is_ccc[k], 1'b0, words[k], k == n - 1, 1'b0);
    end
    @(negedge sys_clk);
    set_config(is_ccc[0], words[0], n == 1);
    @(negedge sys_clk);
    hdr_en = 1'b1;
    for (k = 0; k < n && !timed_out; k++) begin
      wait_rise(is_ccc[k]);
      @(negedge sys_clk);   // word count taken so the next config may follow
      if (k < n - 1)
        set_config(is_ccc[k+1], words[k+1], k + 1 == n - 1);
    end
    wait_done();
  endtask

  task automatic run_abort();
    bit is_ccc;
    int words;
    is_ccc = (rand_range(0, 1) == 1);
    words  = rand_range(2, 6);
    u_hdr_checker.push_expect(is_ccc, 1'b0, words, 1'b0, 1'b1);
    @(negedge sys_clk);
    set_config(is_ccc, words, 1'b1);
    @(negedge sys_clk);
    hdr_en = 1'b1;
    wait_rise(is_ccc);
    repeat (rand_range(1, words * `HDR_WORD_CYCLES - 2)) @(negedge sys_clk);
    hdr_en = 1'b0;   // main engine pulls out mid-transfer
  endtask

  initial begin
    seed         = 32'ha6da9c78;
    timed_out    = 1'b0;
    sys_rst_n    = 1'b0;
    hdr_en       = 1'b0;
    cp           = 1'b0;
    toc          = 1'b0;
    mode         = `HDR_MODE_DDR;
    ccc_words    = 1;
    ddr_words    = 1;
    regf_rd_data = '0;
    repeat (10) @(negedge sys_clk);
    sys_rst_n = 1'b1;
    repeat (2) @(negedge sys_clk);
    for (t = 0; t < NUM_TESTS && !timed_out; t++) begin
      r            = rand_range(0, 255);
      regf_rd_data = r[`HDR_DATA_W-1:0];
      if (t % 6 == 5)
        run_abort();
      else
        run_chain();
      hdr_en = 1'b0;
      repeat (4) @(negedge sys_clk);   // let the mux drain
      u_hdr_checker.end_test(t);
    end
    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             t, failed_tests, check_count, error_count);
    if (timed_out || error_count != 0 || failed_tests != 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation completed successfully");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/hdr_checker.sv */
// HDR subsystem checker
// watches the top-level ports and compares every transfer, dummy word and
// exit against the queue of expected transfers from the testbench model

`default_nettype none

`include "hdr_defines.svh"

module hdr_checker (
  input  logic                   i_sys_clk,
  input  logic                   i_sys_rst_n,
  input  logic                   i_hdr_en,
  input  logic                   i_ccc_active,
  input  logic                   i_ddr_active,
  input  logic                   i_hdr_done,
  input  logic                   i_tx_en,
  input  logic                   i_scl_pp_od,
  input  logic                   i_regf_rd_en,
  input  logic [`HDR_ADDR_W-1:0] i_regf_addr,
  input  logic [`HDR_DATA_W-1:0] i_regf_rd_data,
  input  logic [`HDR_DATA_W-1:0] i_tx_data,
  output integer                 o_error_count,
  output integer                 o_check_count,
  output integer                 o_failed_tests
);

  bit exp_ccc[$];
  bit exp_dummy[$];
  int exp_words[$];
  int exp_end[$];     // 0 restart, 1 exit, 2 abort

  logic open_seg;
  logic seg_ccc;
  logic seg_dummy;
  int   seg_words;
  int   seg_end;
  int   seg_cycles;   // samples with the active output high
  int   seg_reads;
  int   test_errors;
  logic hdr_en_q;
  logic start_due;

  initial begin
    o_error_count  = 0;
    o_check_count  = 0;
    o_failed_tests = 0;
    test_errors    = 0;
  end

  task automatic push_expect(input bit is_ccc, input bit is_dummy, input int words,
                             input bit exits, input bit aborts);
    exp_ccc.push_back(is_ccc);
    exp_dummy.push_back(is_dummy);
    exp_words.push_back(words);
    exp_end.push_back(aborts ? 2 : (exits ? 1 : 0));
  endtask

  task automatic check_val(input string name, input int expected, input int got);
    o_check_count++;
    if (expected != got) begin
      $display("mismatch at %0t: %s expected %0d got %0d", $time, name, expected, got);
      o_error_count++;
      test_errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    o_error_count++;
    test_errors++;
  endtask

  task automatic open_segment();
    if (exp_ccc.size() == 0) begin
      report_error("a transfer started that the model did not predict");
      seg_dummy = 1'b0;
      seg_words = 0;
      seg_end   = 2;   // nothing to compare its length with
    end else begin
      check_val("o_ccc_active", exp_ccc[0], i_ccc_active);
      check_val("o_ddr_active", !exp_ccc[0], i_ddr_active);
      void'(exp_ccc.pop_front());
      seg_dummy = exp_dummy.pop_front();
      seg_words = exp_words.pop_front();
      seg_end   = exp_end.pop_front();
    end
    seg_ccc    = i_ccc_active;
    open_seg   = 1'b1;
    seg_cycles = 1;
    seg_reads  = 0;
  endtask

  task automatic close_segment();
    open_seg = 1'b0;
    check_val("o_hdr_done", seg_end == 1, i_hdr_done);
    if (seg_end != 2) begin
      // N words from enable edge to done plus one edge to exit or restart
      check_val(seg_ccc ? "o_ccc_active cycles" : "o_ddr_active cycles",
                seg_words * `HDR_WORD_CYCLES + 1, seg_cycles);
      check_val("o_regf_rd_en pulses", seg_words, seg_reads);
      check_val("o_tx_en", 0, i_tx_en);
      check_val("o_regf_addr", `HDR_ADDR_IDLE, i_regf_addr);
    end
  endtask

  task automatic end_test(input int idx);
    if (open_seg || exp_ccc.size() != 0)
      report_error("predicted transfers did not all take place");
    if (test_errors == 0) begin
      $display("test %0d passed", idx);
    end else begin
      $display("test %0d failed with %0d errors", idx, test_errors);
      o_failed_tests++;
    end
    test_errors = 0;
    open_seg    = 1'b0;
    exp_ccc.delete();
    exp_dummy.delete();
    exp_words.delete();
    exp_end.delete();
  endtask

  always @(posedge i_sys_clk) begin
    if (!i_sys_rst_n) begin
      open_seg  = 1'b0;
      hdr_en_q  = 1'b0;
      start_due = 1'b0;
    end else begin
      if (start_due && !(i_ccc_active ^ i_ddr_active))
        report_error("no single transfer started one cycle after i_hdr_en rose");
      start_due = i_hdr_en && !hdr_en_q;
      if (open_seg) begin
        if (seg_ccc ? i_ddr_active : i_ccc_active)
          report_error("o_ccc_active and o_ddr_active high together");
        if (seg_ccc ? i_ccc_active : i_ddr_active) begin
          if (!hdr_en_q)
            report_error("a transfer stayed active a cycle after i_hdr_en dropped");
          seg_cycles++;
          check_val("o_hdr_done", 0, i_hdr_done);
          if (i_regf_rd_en) begin
            check_val("o_tx_en", 1, i_tx_en);
            check_val("o_regf_addr", seg_dummy ? `HDR_ADDR_DUMMY :
                      (seg_ccc ? `HDR_ADDR_IDLE : `HDR_ADDR_IDLE + 1 + seg_reads),
                      i_regf_addr);
            seg_reads++;
          end
          if (i_tx_en) begin
            check_val("o_scl_pp_od", !seg_dummy, i_scl_pp_od);  // dummy is open-drain
            check_val("o_tx_data", i_regf_rd_data, i_tx_data);
          end
        end else begin
          close_segment();
        end
      end else if (i_hdr_done) begin
        report_error("o_hdr_done pulsed outside the end of a transfer");
      end
      if (!open_seg && (i_ccc_active || i_ddr_active))
        open_segment();
      hdr_en_q = i_hdr_en;   // last sample for the edge and drop checks
    end
  end

endmodule

`default_nettype wire

/* rtl/hdr_top.sv */
// HDR control subsystem top
// engine FSM, CCC and DDR sequencers and the shared path mux

`default_nettype none

`include "hdr_defines.svh"

module hdr_top (
  input  logic                   i_sys_clk,
  input  logic                   i_sys_rst_n,
  input  logic                   i_hdr_en,
  input  logic                   i_cp,
  input  logic                   i_toc,
  input  logic [2:0]             i_mode,
  input  logic [`HDR_LEN_W-1:0]  i_ccc_words,
  input  logic [`HDR_LEN_W-1:0]  i_ddr_words,
  input  logic [`HDR_DATA_W-1:0] i_regf_rd_data,
  output logic                   o_tx_en,
  output logic                   o_scl_pp_od,
  output logic                   o_regf_rd_en,
  output logic [`HDR_ADDR_W-1:0] o_regf_addr,
  output logic [`HDR_DATA_W-1:0] o_tx_data,
  output logic                   o_hdr_done,
  output logic                   o_ccc_active,
  output logic                   o_ddr_active
);
  import hdr_pkg::*;

  hdr_sel_t               path_sel;
  logic                   ccc_en;
  logic                   ddr_en;
  logic                   dummy_conf;
  logic                   ccc_done;
  logic                   ddr_done;
  logic                   ccc_tx_en;
  logic                   ccc_scl_pp_od;
  logic                   ccc_regf_rd_en;
  logic [`HDR_ADDR_W-1:0] ccc_regf_addr;
  logic                   ddr_tx_en;
  logic                   ddr_scl_pp_od;
  logic                   ddr_regf_rd_en;
  logic [`HDR_ADDR_W-1:0] ddr_regf_addr;

  assign o_ccc_active = ccc_en;
  assign o_ddr_active = ddr_en;

  hdr_engine u_hdr_engine (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst_n  (i_sys_rst_n),
    .i_hdr_en     (i_hdr_en),
    .i_cp         (i_cp),
    .i_toc        (i_toc),
    .i_mode       (i_mode),
    .i_ccc_done   (ccc_done),
    .i_ddr_done   (ddr_done),
    .o_ccc_en     (ccc_en),
    .o_ddr_en     (ddr_en),
    .o_dummy_conf (dummy_conf),
    .o_path_sel   (path_sel),
    .o_hdr_done   (o_hdr_done)
  );

  hdr_ccc_seq u_hdr_ccc_seq (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst_n  (i_sys_rst_n),
    .i_ccc_en     (ccc_en),
    .i_dummy_conf (dummy_conf),
    .i_ccc_words  (i_ccc_words),
    .o_ccc_done   (ccc_done),
    .o_tx_en      (ccc_tx_en),
    .o_scl_pp_od  (ccc_scl_pp_od),
    .o_regf_rd_en (ccc_regf_rd_en),
    .o_regf_addr  (ccc_regf_addr)
  );

  hdr_ddr_seq u_hdr_ddr_seq (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst_n  (i_sys_rst_n),
    .i_ddr_en     (ddr_en),
    .i_ddr_words  (i_ddr_words),
    .o_ddr_done   (ddr_done),
    .o_tx_en      (ddr_tx_en),
    .o_scl_pp_od  (ddr_scl_pp_od),
    .o_regf_rd_en (ddr_regf_rd_en),
    .o_regf_addr  (ddr_regf_addr)
  );

  hdr_path_mux u_hdr_path_mux (
    .i_sys_clk        (i_sys_clk),
    .i_sys_rst_n      (i_sys_rst_n),
    .i_path_sel       (path_sel),
    .i_ccc_tx_en      (ccc_tx_en),
    .i_ccc_scl_pp_od  (ccc_scl_pp_od),
    .i_ccc_regf_rd_en (ccc_regf_rd_en),
    .i_ccc_regf_addr  (ccc_regf_addr),
    .i_ddr_tx_en      (ddr_tx_en),
    .i_ddr_scl_pp_od  (ddr_scl_pp_od),
    .i_ddr_regf_rd_en (ddr_regf_rd_en),
    .i_ddr_regf_addr  (ddr_regf_addr),
    .i_regf_rd_data   (i_regf_rd_data),
    .o_tx_en          (o_tx_en),
    .o_scl_pp_od      (o_scl_pp_od),
    .o_regf_rd_en     (o_regf_rd_en),
    .o_regf_addr      (o_regf_addr),
    .o_tx_data        (o_tx_data)
  );

endmodule

`default_nettype wire

/* rtl/hdr_engine/hdr_path_mux.sv */
// shared path mux
// hands the transmitter, SCL drive and register-file port to the selected
// sequencer, one register stage on every shared control

`default_nettype none

`include "hdr_defines.svh"

module hdr_path_mux (
  input  logic                   i_sys_clk,
  input  logic                   i_sys_rst_n,
  input  hdr_pkg::hdr_sel_t      i_path_sel,
  input  logic                   i_ccc_tx_en,
  input  logic                   i_ccc_scl_pp_od,
  input  logic                   i_ccc_regf_rd_en,
  input  logic [`HDR_ADDR_W-1:0] i_ccc_regf_addr,
  input  logic                   i_ddr_tx_en,
  input  logic                   i_ddr_scl_pp_od,
  input  logic                   i_ddr_regf_rd_en,
  input  logic [`HDR_ADDR_W-1:0] i_ddr_regf_addr,
  input  logic [`HDR_DATA_W-1:0] i_regf_rd_data,
  output logic                   o_tx_en,
  output logic                   o_scl_pp_od,
  output logic                   o_regf_rd_en,
  output logic [`HDR_ADDR_W-1:0] o_regf_addr,
  output logic [`HDR_DATA_W-1:0] o_tx_data
);
  import hdr_pkg::*;

  logic                   sel_ccc;
  logic                   tx_en_mx;
  logic [`HDR_ADDR_W-1:0] addr_mx;

  assign sel_ccc  = (i_path_sel == SEL_CCC);
  assign tx_en_mx = sel_ccc ? i_ccc_tx_en : i_ddr_tx_en;
  assign addr_mx  = sel_ccc ? i_ccc_regf_addr : i_ddr_regf_addr;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      o_tx_en      <= 1'b0;
      o_scl_pp_od  <= 1'b0;
      o_regf_rd_en <= 1'b0;
      o_regf_addr  <= `HDR_ADDR_IDLE;
      o_tx_data    <= '0;
    end else begin
      o_tx_en      <= tx_en_mx;
      o_scl_pp_od  <= sel_ccc ? i_ccc_scl_pp_od : i_ddr_scl_pp_od;
      o_regf_rd_en <= sel_ccc ? i_ccc_regf_rd_en : i_ddr_regf_rd_en;
      o_regf_addr  <= tx_en_mx ? addr_mx : `HDR_ADDR_IDLE;  // park when silent
      o_tx_data    <= tx_en_mx ? i_regf_rd_data : '0;
    end
  end

endmodule

`default_nettype wire

/* rtl/hdr_engine/hdr_ddr_seq.sv */
// HDR-DDR data sequencer
// counts data words on bit and frame ticks from the enable edge, keeps SCL
// push-pull and reads one register per word at a rising address

`default_nettype none

`include "hdr_defines.svh"

module hdr_ddr_seq (
  input  logic                   i_sys_clk,
  input  logic                   i_sys_rst_n,
  input  logic                   i_ddr_en,
  input  logic [`HDR_LEN_W-1:0]  i_ddr_words,
  output logic                   o_ddr_done,
  output logic                   o_tx_en,
  output logic                   o_scl_pp_od,
  output logic                   o_regf_rd_en,
  output logic [`HDR_ADDR_W-1:0] o_regf_addr
);

  localparam logic [`HDR_CYC_W-1:0] LAST_CYC = `HDR_WORD_CYCLES - 1;
  localparam logic [`HDR_CYC_W-1:0] CYC_ONE  = 1;

  logic                  en_q;
  logic                  start;
  logic                  busy;
  logic                  frame_end;
  logic [`HDR_CYC_W-1:0] bit_cnt;      // bit pair ticks within a frame
  logic [`HDR_LEN_W-1:0] frames_left;

  assign start     = i_ddr_en & ~en_q;
  assign frame_end = busy & (bit_cnt == LAST_CYC);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      en_q         <= 1'b0;
      busy         <= 1'b0;
      bit_cnt      <= '0;
      frames_left  <= '0;
      o_ddr_done   <= 1'b0;
      o_tx_en      <= 1'b0;
      o_scl_pp_od  <= 1'b0;
      o_regf_rd_en <= 1'b0;
      o_regf_addr  <= `HDR_ADDR_IDLE;
    end else begin
      en_q         <= i_ddr_en;
      o_ddr_done   <= 1'b0;
      o_regf_rd_en <= 1'b0;
      if (!i_ddr_en) begin
        busy        <= 1'b0;
        o_tx_en     <= 1'b0;
        o_scl_pp_od <= 1'b0;
        o_regf_addr <= `HDR_ADDR_IDLE;
      end else if (start) begin
        busy         <= 1'b1;
        bit_cnt      <= CYC_ONE;
        frames_left  <= i_ddr_words - 1'b1;
        o_tx_en      <= 1'b1;
        o_scl_pp_od  <= 1'b1;
        o_regf_rd_en <= 1'b1;
        o_regf_addr  <= `HDR_ADDR_IDLE + 1'b1;   // first data word
      end else if (busy) begin
        if (frame_end) begin
          bit_cnt <= '0;
          if (frames_left == '0) begin
            busy        <= 1'b0;
            o_ddr_done  <= 1'b1;
            o_tx_en     <= 1'b0;
            o_scl_pp_od <= 1'b0;
            o_regf_addr <= `HDR_ADDR_IDLE;
          end else begin
            frames_left  <= frames_left - 1'b1;
            o_regf_rd_en <= 1'b1;
            o_regf_addr  <= o_regf_addr + 1'b1;  // next data word
          end
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/hdr_engine/hdr_ccc_seq.sv */
// CCC sequencer
// counts command words, or a single dummy word, from the rising edge of
// its enable and pulses done at the end. strobes a register read per word

`default_nettype none

`include "hdr_defines.svh"

module hdr_ccc_seq (
  input  logic                   i_sys_clk,
  input  logic                   i_sys_rst_n,
  input  logic                   i_ccc_en,
  input  logic                   i_dummy_conf,
  input  logic [`HDR_LEN_W-1:0]  i_ccc_words,
  output logic                   o_ccc_done,
  output logic                   o_tx_en,
  output logic                   o_scl_pp_od,
  output logic                   o_regf_rd_en,
  output logic [`HDR_ADDR_W-1:0] o_regf_addr
);

  localparam logic [`HDR_CYC_W-1:0] LAST_CYC = `HDR_WORD_CYCLES - 1;
  localparam logic [`HDR_CYC_W-1:0] CYC_ONE  = 1;

  logic                  en_q;
  logic                  start;
  logic                  busy;
  logic                  word_end;
  logic [`HDR_CYC_W-1:0] cyc_cnt;
  logic [`HDR_LEN_W-1:0] words_left;   // words after the current one

  assign start    = i_ccc_en & ~en_q;
  assign word_end = busy & (cyc_cnt == LAST_CYC);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      en_q         <= 1'b0;
      busy         <= 1'b0;
      cyc_cnt      <= '0;
      words_left   <= '0;
      o_ccc_done   <= 1'b0;
      o_tx_en      <= 1'b0;
      o_scl_pp_od  <= 1'b0;
      o_regf_rd_en <= 1'b0;
      o_regf_addr  <= `HDR_ADDR_IDLE;
    end else begin
      en_q         <= i_ccc_en;
      o_ccc_done   <= 1'b0;
      o_regf_rd_en <= 1'b0;
      if (!i_ccc_en) begin
        busy        <= 1'b0;
        o_tx_en     <= 1'b0;
        o_scl_pp_od <= 1'b0;
        o_regf_addr <= `HDR_ADDR_IDLE;
      end else if (start) begin
        busy         <= 1'b1;
        cyc_cnt      <= CYC_ONE;   // start cycle is cycle 0 of word 0
        words_left   <= i_dummy_conf ? '0 : i_ccc_words - 1'b1;
        o_tx_en      <= 1'b1;
        o_scl_pp_od  <= ~i_dummy_conf;    // dummy word stays open-drain
        o_regf_rd_en <= 1'b1;
        o_regf_addr  <= i_dummy_conf ? `HDR_ADDR_DUMMY : `HDR_ADDR_IDLE;
      end else if (busy) begin
        if (word_end) begin
          cyc_cnt <= '0;
          if (words_left == '0) begin
            busy        <= 1'b0;   // idle until enable toggles
            o_ccc_done  <= 1'b1;
            o_tx_en     <= 1'b0;
            o_scl_pp_od <= 1'b0;
            o_regf_addr <= `HDR_ADDR_IDLE;
          end else begin
            words_left   <= words_left - 1'b1;
            o_regf_rd_en <= 1'b1;   // fetch next command word
          end
        end else begin
          cyc_cnt <= cyc_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/hdr_engine/hdr_engine.sv */
// HDR engine controller FSM
// starts a CCC or DDR transfer from the command-present flag, then at each
// sequencer done either exits (pulses done) or restarts with a fresh config.
// a CCC to DDR restart runs one dummy CCC word before handing over to DDR

`default_nettype none

`include "hdr_defines.svh"

module hdr_engine (
  input  logic              i_sys_clk,
  input  logic              i_sys_rst_n,
  input  logic              i_hdr_en,
  input  logic              i_cp,
  input  logic              i_toc,
  input  logic [2:0]        i_mode,
  input  logic              i_ccc_done,
  input  logic              i_ddr_done,
  output logic              o_ccc_en,
  output logic              o_ddr_en,
  output logic              o_dummy_conf,
  output hdr_pkg::hdr_sel_t o_path_sel,
  output logic              o_hdr_done
);
  import hdr_pkg::*;

  hdr_state_t state;
  logic       hdr_en_q;     // for rising edge of the engine enable
  logic       cp_q;
  logic       toc_q;
  logic [2:0] mode_q;
  logic       dummy_pend;   // dummy CCC word owed before DDR
  logic       seq_done;
  logic       do_exit;

  // done of whichever sequencer the FSM is running
  assign seq_done = ((state == HDR_CCC) & i_ccc_done) |
                    ((state == HDR_DDR) & i_ddr_done);

  // toc set or leaving DDR mode ends the HDR session
  assign do_exit = toc_q | (mode_q != `HDR_MODE_DDR);

  assign o_dummy_conf = dummy_pend;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      state      <= HDR_IDLE;
      hdr_en_q   <= 1'b0;
      cp_q       <= 1'b0;
      toc_q      <= 1'b0;
      mode_q     <= `HDR_MODE_DDR;
      dummy_pend <= 1'b0;
      o_ccc_en   <= 1'b0;
      o_ddr_en   <= 1'b0;
      o_path_sel <= SEL_DDR;
      o_hdr_done <= 1'b0;
    end else begin
      hdr_en_q   <= i_hdr_en;
      o_hdr_done <= 1'b0;   // single cycle pulse
      case (state)
        HDR_IDLE: begin
          // config tracked every cycle, start uses last cycle's copy
          cp_q   <= i_cp;
          toc_q  <= i_toc;
          mode_q <= i_mode;
          if (i_hdr_en && !hdr_en_q) begin
            if (cp_q) begin
              state      <= HDR_CCC;
              o_ccc_en   <= 1'b1;
              o_path_sel <= SEL_CCC;
            end else begin
              state      <= HDR_DDR;
              o_ddr_en   <= 1'b1;
              o_path_sel <= SEL_DDR;
            end
          end
        end

        HDR_CCC, HDR_DDR: begin
          if (!i_hdr_en) begin
            // main engine pulled out, abort without done
            state      <= HDR_IDLE;
            dummy_pend <= 1'b0;
            o_ccc_en   <= 1'b0;
            o_ddr_en   <= 1'b0;
          end else if (seq_done) begin
            // enables drop here, a restart re-arms them next cycle
            o_ccc_en <= 1'b0;
            o_ddr_en <= 1'b0;
            if (dummy_pend) begin
              dummy_pend <= 1'b0;         // dummy word sent, on to DDR
              state      <= HDR_DDR;
              o_path_sel <= SEL_DDR;
            end else if (do_exit) begin
              o_hdr_done <= 1'b1;
              state      <= HDR_IDLE;
            end else begin
              cp_q   <= i_cp;
              toc_q  <= i_toc;
              mode_q <= i_mode;
              if (i_cp) begin
                state      <= HDR_CCC;
                o_path_sel <= SEL_CCC;
              end else if (state == HDR_CCC) begin
                dummy_pend <= 1'b1;       // one more CCC run with dummy config
              end else begin
                state      <= HDR_DDR;
                o_path_sel <= SEL_DDR;
              end
            end
          end else begin
            // hold the running enable, raise it after a restart gap
            o_ccc_en <= (state == HDR_CCC);
            o_ddr_en <= (state == HDR_DDR);
          end
        end

        default: begin
          state    <= HDR_IDLE;
          o_ccc_en <= 1'b0;
          o_ddr_en <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* common/hdr_pkg.sv */
// HDR control subsystem types
// FSM states of the HDR engine and the shared path select

`default_nettype none

package hdr_pkg;

  // engine FSM, one state per active sequencer
  typedef enum logic [1:0] {
    HDR_IDLE = 2'd0,
    HDR_CCC  = 2'd1,
    HDR_DDR  = 2'd2
  } hdr_state_t;

  // owner of the shared transmit, SCL and register-file controls
  typedef enum logic {
    SEL_DDR = 1'b0,
    SEL_CCC = 1'b1
  } hdr_sel_t;

endpackage

`default_nettype wire

/* common/hdr_defines.svh */
// HDR control subsystem constants
// mode code, register-file addresses, word timing and counter widths

`ifndef HDR_DEFINES_SVH
`define HDR_DEFINES_SVH

// mode field value that keeps the controller in HDR-DDR
`define HDR_MODE_DDR    3'd6

`define HDR_ADDR_W      12
`define HDR_ADDR_IDLE   12'd1000  // default register address
`define HDR_ADDR_DUMMY  12'd450   // dummy configuration word

`define HDR_WORD_CYCLES 10        // 20 bits per word, two bits per clock
`define HDR_CYC_W       4         // holds 0 .. HDR_WORD_CYCLES-1
`define HDR_LEN_W       4         // word count inputs
`define HDR_DATA_W      8         // register-file read data

`endif
